//--- binFilter.sv
/* stamps arrive sample innermost, then pixel, then acquisition
   no handshake, upstream idles at least four cycles after the last sample of a pass */

`timescale 1ns/1ns
`include "sifh_cfg.svh"

module binFilter (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                wrEn,
    input  logic [`SIFH_NP-1:0] data,
    input  sifhPkg::windowArrT  window,
    output sifhPkg::binReqT     binReq
);
    import sifhPkg::*;

    localparam int NP       = `SIFH_NP;
    localparam int NB       = `SIFH_NB;
    localparam int PIX_W    = `SIFH_PIX_W;
    localparam int SAMPLE_W = $clog2(`SIFH_DATA_NUM);
    localparam int ACQ_W    = $clog2(`SIFH_ACQ_NUM);

    localparam logic [SAMPLE_W-1:0] LAST_SAMPLE = SAMPLE_W'(`SIFH_DATA_NUM - 1);
    localparam logic [PIX_W-1:0]    LAST_PIXEL  = PIX_W'(`SIFH_PIXELS - 1);
    localparam logic [ACQ_W-1:0]    LAST_ACQ    = ACQ_W'(`SIFH_ACQ_NUM - 1);

    // position inside the pass
    logic [SAMPLE_W-1:0] sampleCnt;
    logic [PIX_W-1:0]    pixelCnt;
    logic [ACQ_W-1:0]    acqCnt;
    passT                pass;

    logic                lastSample;
    logic                lastPixel;
    logic                lastAcq;
    logic                lastOfPass;

    // window of the pixel being sampled
    windowT              pixWindow;
    logic                inWindow;
    logic [NB-1:0]       binAddr;

    // ***********************************************************************
    // position decode
    // ***********************************************************************

    assign lastSample = (sampleCnt == LAST_SAMPLE);
    assign lastPixel  = (pixelCnt == LAST_PIXEL);
    assign lastAcq    = (acqCnt == LAST_ACQ);
    // final stamp of the whole pass
    assign lastOfPass = lastSample && lastPixel && lastAcq;

    // ***********************************************************************
    // bin selection
    // ***********************************************************************

    assign pixWindow = window[pixelCnt];
    // inclusive bounds, upper edge maps onto the discard bin
    assign inWindow  = (data >= pixWindow.lower) && (data <= pixWindow.upper);

    always_comb begin
        if (pass == COARSE) begin
            // coarse bin from the top stamp bits
            binAddr = data[NP-1 -: NB];
        end else if (inWindow) begin
            // offset-corrected low bits
            binAddr = NB'(data - pixWindow.lower);
        end else begin
            binAddr = DISCARD_BIN;
        end
    end

    // ***********************************************************************
    // counters, pass register and request register
    // ***********************************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
            pass      <= COARSE;
            binReq    <= '0;
        end else begin
            if (wrEn) begin
                // sample index innermost
                sampleCnt <= lastSample ? '0 : sampleCnt + 1'b1;
                if (lastSample) begin
                    pixelCnt <= lastPixel ? '0 : pixelCnt + 1'b1;
                    if (lastPixel) begin
                        acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                    end
                end
                // passes alternate for as long as samples arrive
                if (lastOfPass) begin
                    pass <= (pass == COARSE) ? FINE : COARSE;
                end
            end
            // one request per strobe, pass as seen by the stamp
            binReq.valid      <= wrEn;
            binReq.pixel      <= pixelCnt;
            binReq.bin        <= binAddr;
            binReq.lastOfPass <= wrEn && lastOfPass;
            binReq.pass       <= pass;
        end
    end

endmodule

//--- flist.f
+incdir+.
sifhPkg.sv
binFilter.sv
histogramRam.sv
peakWindowCalc.sv
sifhTop.sv
sifhTb.sv

//--- histogramRam.sv
/* one counter and one valid bit per pixel per bin, lazily cleared by valid bits
   valid bits drop one cycle after the last request of a pass is counted */

`timescale 1ns/1ns
`include "sifh_cfg.svh"

module histogramRam (
    input  logic              clk,
    input  logic              combin_res,
    input  sifhPkg::binReqT   binReq,
    output sifhPkg::binCountT binCount
);
    import sifhPkg::*;

    localparam int PIXELS = `SIFH_PIXELS;
    localparam int BINS   = 1 << `SIFH_NB;
    localparam int CNT_W  = `SIFH_CNT_W;

    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    // bin counters, pixel major
    logic [CNT_W-1:0]             counter [PIXELS][BINS];
    // set once the bin was hit in the running pass
    logic [PIXELS-1:0][BINS-1:0]  binValid;
    // last request of a pass was counted
    logic                         clearPending;

    logic [CNT_W-1:0]             oldCount;
    logic                         oldValid;
    logic                         discard;
    logic                         doCount;
    logic [CNT_W-1:0]             newCount;

    // ***********************************************************************
    // read and saturating increment
    // ***********************************************************************

    assign oldCount = counter[binReq.pixel][binReq.bin];
    assign oldValid = binValid[binReq.pixel][binReq.bin];

    // all-ones is a real bin in the coarse pass
    assign discard  = (binReq.pass == FINE) && (binReq.bin == DISCARD_BIN);
    assign doCount  = binReq.valid && !discard;

    always_comb begin
        if (!oldValid) begin
            // stale count from an earlier pass
            newCount = CNT_W'(1);
        end else if (oldCount == CNT_MAX) begin
            newCount = oldCount;
        end else begin
            newCount = oldCount + 1'b1;
        end
    end

    // ***********************************************************************
    // write back and count register
    // ***********************************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXELS; p++) begin
                for (int b = 0; b < BINS; b++) begin
                    counter[p][b] <= '0;
                end
            end
            binValid     <= '0;
            clearPending <= 1'b0;
            binCount     <= '0;
        end else begin
            if (doCount) begin
                counter[binReq.pixel][binReq.bin]  <= newCount;
                binValid[binReq.pixel][binReq.bin] <= 1'b1;
            end
            // whole memory empty for the next pass
            if (clearPending) begin
                binValid <= '0;
            end
            clearPending <= binReq.valid && binReq.lastOfPass;

            // discarded stamp still carries the end of pass
            binCount.valid      <= doCount;
            binCount.pixel      <= binReq.pixel;
            binCount.bin        <= binReq.bin;
            binCount.count      <= newCount;
            binCount.lastOfPass <= binReq.valid && binReq.lastOfPass;
            binCount.pass       <= binReq.pass;
        end
    end

endmodule

//--- peakWindowCalc.sv
/* ties keep the first bin to reach the count
   window and result update one cycle after the last count of a pass */

`timescale 1ns/1ns
`include "sifh_cfg.svh"

module peakWindowCalc (
    input  logic               clk,
    input  logic               combin_res,
    input  sifhPkg::binCountT  binCount,
    output sifhPkg::windowArrT window,
    output sifhPkg::resultArrT result,
    output logic               resultValid
);
    import sifhPkg::*;

    localparam int NP     = `SIFH_NP;
    localparam int NB     = `SIFH_NB;
    localparam int PIXELS = `SIFH_PIXELS;
    localparam int CNT_W  = `SIFH_CNT_W;

    // half-width of the window
    localparam logic [NP-1:0] SB         = NP'(1 << (NB - 1));
    localparam logic [NP-1:0] MAX_STAMP  = '1;
    // centers above this clamp to the top edge
    localparam logic [NP-1:0] HIGH_LIMIT = MAX_STAMP - NP'(2) * SB - NP'(1);
    localparam logic [NP-1:0] HIGH_LOWER = NP'((1 << NP) - (1 << NB));
    // window spans one coarse bin
    localparam logic [NP-1:0] SPAN       = NP'((1 << NB) - 1);

    // running maximum per pixel
    logic [CNT_W-1:0] maxCnt  [PIXELS];
    logic [NB-1:0]    peakBin [PIXELS];

    // pass that has just ended
    logic             endPending;
    passT             endPass;

    windowArrT        nextWindow;

    // ***********************************************************************
    // window computation from the coarse peak
    // ***********************************************************************

    function automatic windowT makeWindow(input logic [NB-1:0] peak);
        logic [NP-1:0] center;
        logic [NP-1:0] lower;
        windowT        win;
        center = {peak, {(NP - NB){1'b0}}};
        if (center <= SB) begin
            lower = '0;
        end else if (center > HIGH_LIMIT) begin
            lower = HIGH_LOWER;
        end else begin
            lower = center - SB;
        end
        win.lower = lower;
        win.upper = lower + SPAN;
        return win;
    endfunction

    always_comb begin
        for (int p = 0; p < PIXELS; p++) begin
            nextWindow[p] = makeWindow(peakBin[p]);
        end
    end

    // ***********************************************************************
    // peak tracking and pass end
    // ***********************************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXELS; p++) begin
                maxCnt[p]  <= '0;
                peakBin[p] <= '0;
            end
            endPending  <= 1'b0;
            endPass     <= COARSE;
            window      <= '0;
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            endPending  <= binCount.lastOfPass;
            endPass     <= binCount.pass;

            // strictly greater, first arrival wins
            if (binCount.valid && (binCount.count > maxCnt[binCount.pixel])) begin
                maxCnt[binCount.pixel]  <= binCount.count;
                peakBin[binCount.pixel] <= binCount.bin;
            end

            if (endPending) begin
                if (endPass == COARSE) begin
                    window <= nextWindow;
                end else begin
                    // fine peak plus window offset
                    for (int p = 0; p < PIXELS; p++) begin
                        result[p] <= {{(NP - NB){1'b0}}, peakBin[p]} + window[p].lower;
                    end
                    resultValid <= 1'b1;
                end
                // fresh maxima for the next pass
                for (int p = 0; p < PIXELS; p++) begin
                    maxCnt[p]  <= '0;
                    peakBin[p] <= '0;
                end
            end
        end
    end

endmodule

//--- run.sh
#!/bin/bash
# build and run the testbench with Verilator, pass decided from the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module sifhTb -f flist.f -o sifhSim \
    && ./obj_dir/sifhSim | tee /dev/stderr | grep -qx "Testbench passed" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }

exit 0

//--- sifhPkg.sv
/* types shared by filter, histogram and peak unit
   all-ones bin is reserved as discard during the fine pass only */

`include "sifh_cfg.svh"

package sifhPkg;

    // current histogram pass
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } passT;

    // reserved fine-pass bin, stamp outside the window
    localparam logic [`SIFH_NB-1:0] DISCARD_BIN = '1;

    // filter to histogram, one per strobe
    typedef struct packed {
        logic                   valid;
        logic [`SIFH_PIX_W-1:0] pixel;
        logic [`SIFH_NB-1:0]    bin;
        logic                   lastOfPass;
        passT                   pass;
    } binReqT;

    // histogram to peak unit, new count of the addressed bin
    typedef struct packed {
        logic                   valid;
        logic [`SIFH_PIX_W-1:0] pixel;
        logic [`SIFH_NB-1:0]    bin;
        logic [`SIFH_CNT_W-1:0] count;
        logic                   lastOfPass;
        passT                   pass;
    } binCountT;

    // fine window of one pixel, inclusive stamp bounds
    typedef struct packed {
        logic [`SIFH_NP-1:0] lower;
        logic [`SIFH_NP-1:0] upper;
    } windowT;

    // windows of all pixels, peak unit back to filter
    typedef windowT [`SIFH_PIXELS-1:0] windowArrT;

    // final peak stamp per pixel
    typedef logic [`SIFH_PIXELS-1:0][`SIFH_NP-1:0] resultArrT;

endpackage

//--- sifhTb.sv
/* random stimulus from a fixed seed, one coarse and one fine pass per frame
   bin counters cannot reach saturation within one pass of these sizes */

`timescale 1ns/1ns
`include "sifh_cfg.svh"

module sifhTb;
    import sifhPkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int NP            = `SIFH_NP;
    localparam int NB            = `SIFH_NB;
    localparam int PIXELS        = `SIFH_PIXELS;
    localparam int DATA_NUM      = `SIFH_DATA_NUM;
    localparam int ACQ_NUM       = `SIFH_ACQ_NUM;
    // stamps per pixel per pass
    localparam int SAMPLES_PP    = DATA_NUM * ACQ_NUM;
    localparam int BINS          = 1 << NB;
    localparam int MAX_STAMP     = (1 << NP) - 1;
    localparam int CNT_MAX       = (1 << `SIFH_CNT_W) - 1;
    localparam int FRAME_SAMPLES = 2 * PIXELS * SAMPLES_PP;
    localparam int NUM_TESTS     = 6;
    localparam int WATCHDOG_NS   = NUM_TESTS * FRAME_SAMPLES * CLK_PERIOD * 4;
    localparam int SEED          = 32'h1ab6_6134;
    // stimulus shapes
    localparam int MID  = 0;
    localparam int LOW  = 1;
    localparam int HIGH = 2;
    localparam int TIE  = 3;

    logic            clk;
    logic            combin_res;
    logic            wrEn;
    logic [NP-1:0]   data;
    resultArrT       result;
    logic            resultValid;

    // stamps of one frame, per pixel in arrival order
    int coarseSt  [PIXELS][SAMPLES_PP];
    int fineSt    [PIXELS][SAMPLES_PP];
    int expResult [PIXELS];
    int testErrors;
    int passCount;
    int failCount;

    sifhTop UUT (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .result      (result),
        .resultValid (resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // tests times frame length, four times over
    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    // result pulse lasts one cycle
    pulseWidth: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |=> !resultValid)
    else begin
        $display("resultValid stayed high for more than one cycle at %0t ns", $time);
        testErrors++;
    end

    // ***************************************************************************
    // reference model
    // ***************************************************************************

    function automatic int noisyStamp(input int center, input int spread);
        int s;
        s = center - spread + int'($urandom_range(2 * spread));
        if (s < 0) s = 0;
        if (s > MAX_STAMP) s = MAX_STAMP;
        return s;
    endfunction

    // lower window edge from the coarse peak, clamped at both ends
    function automatic int windowLower(input int peak);
        int center;
        int sb;
        center = peak << (NP - NB);
        sb     = BINS / 2;
        if (center <= sb) return 0;
        if (center > MAX_STAMP - 2 * sb - 1) return (1 << NP) - BINS;
        return center - sb;
    endfunction

    // first bin to reach the highest count
    function automatic int firstPeak(input int stamps[SAMPLES_PP], input bit fine,
                                     input int lower);
        int cnt [BINS];
        int best;
        int peak;
        int bin;
        bit keep;
        best = 0;
        peak = 0;
        foreach (cnt[b]) cnt[b] = 0;
        for (int i = 0; i < SAMPLES_PP; i++) begin
            keep = 1'b1;
            bin  = stamps[i] >> (NP - NB);
            if (fine) begin
                // outside the window, or on the reserved top bin
                bin  = stamps[i] - lower;
                keep = (bin >= 0) && (bin < BINS - 1);
            end
            if (keep) begin
                if (cnt[bin] < CNT_MAX) cnt[bin]++;
                if (cnt[bin] > best) begin
                    best = cnt[bin];
                    peak = bin;
                end
            end
        end
        return peak;
    endfunction

    task automatic modelFrame();
        int lower;
        for (int p = 0; p < PIXELS; p++) begin
            lower        = windowLower(firstPeak(coarseSt[p], 1'b0, 0));
            expResult[p] = firstPeak(fineSt[p], 1'b1, lower) + lower;
        end
    endtask

    // ***************************************************************************
    // stimulus and checks
    // ***************************************************************************

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("** Error at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic endTest(input string name);
        if (testErrors == 0) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic buildFrame(input int mode);
        int center;
        int base;
        for (int p = 0; p < PIXELS; p++) begin
            // tie pattern sits on coarse bins 4, 10, 16, 22
            base = (4 + 6 * p) * BINS;
            case (mode)
                LOW:     center = $urandom_range(12);
                HIGH:    center = 1010 + $urandom_range(13);
                default: center = 200 + $urandom_range(600);
            endcase
            for (int i = 0; i < SAMPLES_PP; i++) begin
                if (mode == TIE && p == PIXELS - 1) begin
                    // every sample of the pass in one bin
                    coarseSt[p][i] = base + 4;
                    fineSt[p][i]   = base + 4;
                end else if (mode == TIE) begin
                    // equal counts, the even samples arrive first
                    coarseSt[p][i] = (i % 2 == 0) ? base + 5 : base + 70;
                    fineSt[p][i]   = (i % 2 == 0) ? base + 9 : base + 2;
                end else begin
                    coarseSt[p][i] = noisyStamp(center, 6);
                    fineSt[p][i]   = noisyStamp(center, 6);
                    // far outliers, dropped by the fine window
                    if (mode == HIGH && i % 8 == 3) begin
                        coarseSt[p][i] = center - 300;
                        fineSt[p][i]   = center - 300;
                    end
                end
            end
        end
    endtask

    task automatic driveStamp(input int s, input int idle);
        @(negedge clk);
        wrEn = 1'b1;
        data = NP'(s);
        checkValue("resultValid", 0, resultValid);
        repeat (idle) begin
            @(negedge clk);
            wrEn = 1'b0;
            checkValue("resultValid", 0, resultValid);
        end
    endtask

    task automatic runPass(input bit fine);
        int  s;
        bit  last;
        for (int acq = 0; acq < ACQ_NUM; acq++) begin
            for (int pix = 0; pix < PIXELS; pix++) begin
                for (int smp = 0; smp < DATA_NUM; smp++) begin
                    s    = fine ? fineSt[pix][acq * DATA_NUM + smp]
                                : coarseSt[pix][acq * DATA_NUM + smp];
                    last = (acq == ACQ_NUM - 1) && (pix == PIXELS - 1) && (smp == DATA_NUM - 1);
                    driveStamp(s, last ? 0 : $urandom_range(2));
                end
            end
        end
        // four idle cycles, result pulse 3 cycles after the last strobe
        for (int i = 1; i <= 4; i++) begin
            @(negedge clk);
            wrEn = 1'b0;
            checkValue("resultValid", (fine && i == 4) ? 1 : 0, resultValid);
        end
        if (fine) begin
            for (int p = 0; p < PIXELS; p++) begin
                checkValue($sformatf("result[%0d]", p), expResult[p], result[p]);
            end
        end
    endtask

    task automatic runFrame(input int mode);
        buildFrame(mode);
        modelFrame();
        runPass(1'b0);
        runPass(1'b1);
    endtask

    initial begin
        void'($urandom(SEED));
        combin_res = 1'b0;
        wrEn       = 1'b0;
        data       = '0;
        testErrors = 0;
        passCount  = 0;
        failCount  = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;

        // no pulse and zero results straight out of reset
        repeat (4) begin
            @(negedge clk);
            checkValue("resultValid", 0, resultValid);
        end
        for (int p = 0; p < PIXELS; p++) begin
            checkValue($sformatf("result[%0d]", p), 0, result[p]);
        end
        endTest("reset state");

        runFrame(MID);
        endTest("mid-range peaks");
        runFrame(LOW);
        endTest("low-edge clamp");
        runFrame(HIGH);
        endTest("high-edge clamp");
        runFrame(TIE);
        endTest("ties and full bin");
        // lazy clear between frames
        repeat (3) runFrame(MID);
        endTest("back-to-back frames");

        $display("tests done: %0d ok, %0d with errors", passCount, failCount);
        if (failCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sifhTop.sv
/* plain write strobe, no back-pressure
   result holds until the next fine pass ends, resultValid pulses for one cycle */

`timescale 1ns/1ns
`include "sifh_cfg.svh"

module sifhTop (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                wrEn,
    input  logic [`SIFH_NP-1:0] data,
    output sifhPkg::resultArrT  result,
    output logic                resultValid
);
    import sifhPkg::*;

    // filter to histogram
    binReqT    binReq;
    // histogram to peak unit
    binCountT  binCount;
    // peak unit back to filter
    windowArrT window;

    // ***********************************************************************
    // producer, buffer, consumer
    // ***********************************************************************

    binFilter uBinFilter (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .data       (data),
        .window     (window),
        .binReq     (binReq)
    );

    histogramRam uHistogramRam (
        .clk        (clk),
        .combin_res (combin_res),
        .binReq     (binReq),
        .binCount   (binCount)
    );

    peakWindowCalc uPeakWindowCalc (
        .clk         (clk),
        .combin_res  (combin_res),
        .binCount    (binCount),
        .window      (window),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

//--- sifh_cfg.svh
/* sizes for the two-pass histogram peak finder
   NP must exceed NB; counters saturate at SIFH_CNT_W bits */

`ifndef SIFH_CFG_SVH
`define SIFH_CFG_SVH

// ***************************************************************************
// stamp and bin geometry
// ***************************************************************************

// time-of-arrival stamp width
`define SIFH_NP        10
// bin address width, one histogram has 2**NB bins
`define SIFH_NB        5

// ***************************************************************************
// array and acquisition sizes
// ***************************************************************************

// pixels sharing one histogram memory
`define SIFH_PIXELS    4
// pixel index width
`define SIFH_PIX_W     $clog2(`SIFH_PIXELS)
// samples per pixel per acquisition
`define SIFH_DATA_NUM  4
// acquisitions per pass
`define SIFH_ACQ_NUM   8
// bin counter width
`define SIFH_CNT_W     8

`endif
